// ==== rtl/wave_mem_config.svh ====
`ifndef WAVE_MEM_CONFIG_SVH
`define WAVE_MEM_CONFIG_SVH

// Wave geometry
`define WM_CORE_COUNT 4
`define WM_XLEN 32

// SRAM shape, one word per 32-bit location
`define WM_WORD_IDX_BITS 10
`define WM_SRAM_WORDS 1024

// Address map
// Instruction fetches below this limit go to the wave-local SRAM
`define WM_INSTR_LIMIT 32'h0000_1000

// Core-private data window
`define WM_PRIV_BASE 32'h0000_2000
`define WM_PRIV_LIMIT 32'h0000_3000 // First address past the window

`endif

// ==== rtl/wave_mem_pkg.sv ====
`include "wave_mem_config.svh"

package wave_mem_pkg;

	// Lane address viewed as fields for SRAM indexing
	typedef struct packed {
		logic [`WM_XLEN-`WM_WORD_IDX_BITS-3:0] upper; // Selects the region
		logic [`WM_WORD_IDX_BITS-1:0] word_idx; // Word inside a 4 KiB window
		logic [1:0] byte_off; // Accesses are word aligned
	} core_addr_fields_t;

	// Region checks use raw, SRAM addressing uses f
	typedef union packed {
		logic [`WM_XLEN-1:0] raw;
		core_addr_fields_t f;
	} core_addr_u;

	typedef struct packed {
		logic instr; // Fetch rather than data access
		core_addr_u addr;
		logic [3:0] wstrb; // Zero means read
		logic [`WM_XLEN-1:0] wdata;
	} lane_req_t;

	// A firmware request carries its address and data in lane 0
	typedef struct packed {
		lane_req_t [`WM_CORE_COUNT-1:0] lane;
		logic fw;
		logic fw_wave_select;
		logic [$clog2(`WM_CORE_COUNT)-1:0] fw_core_select;
	} wave_req_t;

	typedef enum logic [1:0] {
		REGION_NONE = 2'd0,
		REGION_WAVE = 2'd1,
		REGION_PRIV = 2'd2
	} region_e;

	typedef struct packed {
		region_e region;
		logic [`WM_WORD_IDX_BITS-1:0] word_idx;
		logic [3:0] wstrb; // Nonzero strobe makes this a write
		logic [`WM_XLEN-1:0] wdata;
	} lane_op_t;

	typedef struct packed {
		logic lockstep; // Fetch lanes out of step
		logic mem; // Data access into the instruction region
		logic unmapped; // Address hits no memory
	} wave_fault_t;

	typedef struct packed {
		lane_op_t [`WM_CORE_COUNT-1:0] op;
		wave_fault_t fault;
	} dec_req_t;

	typedef struct packed {
		logic [`WM_CORE_COUNT-1:0][`WM_XLEN-1:0] rdata;
		wave_fault_t fault;
	} wave_rsp_t;

endpackage

// ==== rtl/word_sram.sv ====
`timescale 1ns/1ps
`include "wave_mem_config.svh"

// Single-port word SRAM with byte write enables
// Read data is registered and held while rd_en is low
module word_sram (
	input logic clk,
	input logic rd_en,
	input logic wr_en,
	input logic [3:0] byte_en,
	input logic [`WM_WORD_IDX_BITS-1:0] address,
	input logic [`WM_XLEN-1:0] data_in,
	output logic [`WM_XLEN-1:0] data_out
);

	logic [3:0][7:0] mem [`WM_SRAM_WORDS];

	// Write only the enabled byte lanes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (byte_en[b]) begin
					mem[address][b] <= data_in[8*b +: 8];
				end
			end
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (rd_en) begin
			data_out <= mem[address];
		end
	end

endmodule

// ==== rtl/wave_req_decode.sv ====
`timescale 1ns/1ps
`include "wave_mem_config.svh"

// Decode stage: classifies each lane's address, checks lockstep
// and turns the wave request into one memory op per lane
module wave_req_decode (
	input logic clk,
	input logic nRST,
	input logic req_valid,
	output logic req_ready,
	input wave_mem_pkg::wave_req_t req,
	output logic dec_valid,
	input logic dec_ready,
	output wave_mem_pkg::dec_req_t dec
);

	wave_mem_pkg::region_e lane_region [`WM_CORE_COUNT];
	logic [`WM_CORE_COUNT-1:0] lane_skew; // Lane disagrees with lane 0
	logic [`WM_CORE_COUNT-1:0] lane_mem_bad;
	logic [`WM_CORE_COUNT-1:0] lane_unmapped;
	wave_mem_pkg::wave_fault_t run_fault;
	wave_mem_pkg::dec_req_t dec_next;
	logic take_req;

	function automatic wave_mem_pkg::lane_op_t make_op(
		input wave_mem_pkg::region_e region,
		input wave_mem_pkg::lane_req_t lane
	);
		wave_mem_pkg::lane_op_t op;
		op.region = region;
		op.word_idx = lane.addr.f.word_idx;
		op.wstrb = lane.wstrb;
		op.wdata = lane.wdata;
		return op;
	endfunction

	// Per-lane region and fault conditions, lane 0 is the lockstep reference
	always_comb begin
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			if (req.lane[k].instr && req.lane[k].addr.raw < `WM_INSTR_LIMIT) begin
				lane_region[k] = wave_mem_pkg::REGION_WAVE;
			end else if (req.lane[k].addr.raw >= `WM_PRIV_BASE &&
					req.lane[k].addr.raw < `WM_PRIV_LIMIT) begin
				lane_region[k] = wave_mem_pkg::REGION_PRIV;
			end else begin
				lane_region[k] = wave_mem_pkg::REGION_NONE;
			end

			lane_skew[k] = (req.lane[k].instr != req.lane[0].instr) ||
				(req.lane[0].instr && req.lane[k].addr.raw != req.lane[0].addr.raw);

			// A store into instruction space counts as a data access too,
			// so the wave SRAM is never written from run mode
			lane_mem_bad[k] = (req.lane[k].addr.raw < `WM_INSTR_LIMIT) &&
				(!req.lane[k].instr || req.lane[k].wstrb != 4'b0);

			lane_unmapped[k] = (lane_region[k] == wave_mem_pkg::REGION_NONE) &&
				!lane_mem_bad[k];
		end

		run_fault.lockstep = |lane_skew;
		run_fault.mem = |lane_mem_bad;
		run_fault.unmapped = |lane_unmapped;
	end

	// Build the lane ops
	always_comb begin
		dec_next = '0;
		if (req.fw) begin
			// Firmware access never faults, it uses lane 0's address and data
			if (req.fw_wave_select) begin
				dec_next.op[0] = make_op(wave_mem_pkg::REGION_WAVE, req.lane[0]);
			end else begin
				dec_next.op[req.fw_core_select] =
					make_op(wave_mem_pkg::REGION_PRIV, req.lane[0]);
			end
		end else if (run_fault != 3'b000) begin
			dec_next.fault = run_fault; // Faulting wave touches no memory
		end else begin
			for (int k = 0; k < `WM_CORE_COUNT; k++) begin
				dec_next.op[k] = make_op(lane_region[k], req.lane[k]);
			end
		end
	end

	assign req_ready = !dec_valid || dec_ready;
	assign take_req = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (!nRST) begin
			dec_valid <= 1'b0;
		end else if (take_req) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0; // Drained downstream
		end
	end

	always_ff @(posedge clk) begin
		if (take_req) begin
			dec <= dec_next;
		end
	end

endmodule

// ==== rtl/wave_mem_access.sv ====
`timescale 1ns/1ps
`include "wave_mem_config.svh"

// Access stage: drives the wave-local SRAM and the four private SRAMs
// from the decoded lane ops and assembles the wave response
module wave_mem_access (
	input logic clk,
	input logic nRST,
	input logic dec_valid,
	output logic dec_ready,
	input wave_mem_pkg::dec_req_t dec,
	output logic rsp_valid,
	input logic rsp_ready,
	output wave_mem_pkg::wave_rsp_t rsp
);

	logic take;
	logic wave_hit;
	wave_mem_pkg::lane_op_t wave_op; // Op that owns the wave SRAM port
	logic wave_rd_en;
	logic wave_wr_en;
	logic [`WM_XLEN-1:0] wave_q;
	logic [`WM_XLEN-1:0] priv_q [`WM_CORE_COUNT];
	wave_mem_pkg::region_e rd_region [`WM_CORE_COUNT]; // Read source per lane
	wave_mem_pkg::wave_fault_t fault_q;

	// Only take a new op when the response register frees up this cycle
	assign dec_ready = !rsp_valid || rsp_ready;
	assign take = dec_valid && dec_ready;

	// First lane in the wave region wins the port
	// A fetch has identical word indices on every lane anyway
	always_comb begin
		wave_hit = 1'b0;
		wave_op = dec.op[0];
		for (int k = `WM_CORE_COUNT - 1; k >= 0; k--) begin
			if (dec.op[k].region == wave_mem_pkg::REGION_WAVE) begin
				wave_hit = 1'b1;
				wave_op = dec.op[k];
			end
		end
	end

	assign wave_rd_en = take && wave_hit && (wave_op.wstrb == 4'b0);
	assign wave_wr_en = take && wave_hit && (wave_op.wstrb != 4'b0);

	word_sram wave_sram (
		.clk(clk),
		.rd_en(wave_rd_en),
		.wr_en(wave_wr_en),
		.byte_en(wave_op.wstrb),
		.address(wave_op.word_idx),
		.data_in(wave_op.wdata),
		.data_out(wave_q)
	);

	// One private SRAM per core, lane k only
	for (genvar k = 0; k < `WM_CORE_COUNT; k++) begin : priv
		logic sel;
		logic rd_en;
		logic wr_en;

		assign sel = take && (dec.op[k].region == wave_mem_pkg::REGION_PRIV);
		assign rd_en = sel && (dec.op[k].wstrb == 4'b0);
		assign wr_en = sel && (dec.op[k].wstrb != 4'b0);

		word_sram priv_sram (
			.clk(clk),
			.rd_en(rd_en),
			.wr_en(wr_en),
			.byte_en(dec.op[k].wstrb),
			.address(dec.op[k].word_idx),
			.data_in(dec.op[k].wdata),
			.data_out(priv_q[k])
		);
	end

	always_ff @(posedge clk) begin
		if (!nRST) begin
			rsp_valid <= 1'b0;
		end else if (take) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	// Remember where each lane's data comes from
	// Write lanes answer zero since their SRAM output is not refreshed
	always_ff @(posedge clk) begin
		if (take) begin
			fault_q <= dec.fault;
			for (int k = 0; k < `WM_CORE_COUNT; k++) begin
				rd_region[k] <= (dec.op[k].wstrb == 4'b0) ? dec.op[k].region :
					wave_mem_pkg::REGION_NONE;
			end
		end
	end

	// SRAM outputs and rd_region hold under back-pressure, so rsp stays stable
	always_comb begin
		rsp.fault = fault_q;
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			case (rd_region[k])
				wave_mem_pkg::REGION_WAVE: rsp.rdata[k] = wave_q;
				wave_mem_pkg::REGION_PRIV: rsp.rdata[k] = priv_q[k];
				default: rsp.rdata[k] = '0;
			endcase
		end
	end

endmodule

// ==== rtl/wave_mem_top.sv ====
`timescale 1ns/1ps

// Wave memory fabric
// Two pipeline stages, one request per cycle, answers in order
module wave_mem_top (
	input logic clk,
	input logic nRST,
	input logic req_valid,
	output logic req_ready,
	input wave_mem_pkg::wave_req_t req,
	output logic rsp_valid,
	input logic rsp_ready,
	output wave_mem_pkg::wave_rsp_t rsp
);

	// Decode to access handshake
	logic dec_valid;
	logic dec_ready;
	wave_mem_pkg::dec_req_t dec;

	wave_req_decode u_decode (
		.clk(clk),
		.nRST(nRST),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec)
	);

	wave_mem_access u_access (
		.clk(clk),
		.nRST(nRST),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

endmodule

// ==== tests/wave_mem_props.sv ====
`timescale 1ns/1ps

// Response port protocol checks, bound into wave_mem_top
module wave_mem_props (
	input logic clk,
	input logic nRST,
	input logic rsp_valid,
	input logic rsp_ready,
	input wave_mem_pkg::wave_rsp_t rsp
);

	// Synchronous reset clears the response register by the next edge
	rsp_idle_in_reset: assert property (@(posedge clk) !nRST |=> !rsp_valid)
		else $error("rsp_valid is high right after a reset cycle");

	// A stalled response stays valid and unchanged
	rsp_held_under_stall: assert property (@(posedge clk) disable iff (!nRST)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("response changed or dropped while rsp_ready was low");

	fault_rsp_is_zero: assert property (@(posedge clk) disable iff (!nRST)
		rsp_valid && rsp.fault != 3'b000 |-> rsp.rdata == '0)
		else $error("faulting response carries nonzero read data");

endmodule

// ==== tests/wave_mem_checker.sv ====
`timescale 1ns/1ps
`include "wave_mem_config.svh"

// Scoreboard for the wave memory fabric
// Predicts each response from the request stream, compares in order
module wave_mem_checker (
	input logic clk,
	input logic nRST,
	input logic req_valid,
	input logic req_ready,
	input wave_mem_pkg::wave_req_t req,
	input logic rsp_valid,
	input logic rsp_ready,
	input wave_mem_pkg::wave_rsp_t rsp,
	input logic [8*12-1:0] test_name,
	output int checks,
	output int errors,
	output int pending
);

	logic [31:0] wave_shadow [`WM_SRAM_WORDS];
	logic [31:0] priv_shadow [`WM_CORE_COUNT][`WM_SRAM_WORDS];
	wave_mem_pkg::wave_rsp_t expect_q [$]; // Oldest expectation first

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	// Expected response for one request, shadow memories updated as a side effect
	function wave_mem_pkg::wave_rsp_t wave_ref(input wave_mem_pkg::wave_req_t r);
		wave_mem_pkg::wave_rsp_t exp;
		logic [31:0] a;
		logic [9:0] idx;
		logic in_wave;
		logic in_priv;
		logic bad_mem;
		exp = '0;
		if (r.fw) begin
			idx = r.lane[0].addr.raw[11:2];
			if (r.fw_wave_select && r.lane[0].wstrb != 4'h0) begin
				wave_shadow[idx] = merge_bytes(wave_shadow[idx], r.lane[0].wdata, r.lane[0].wstrb);
			end else if (r.fw_wave_select) begin
				exp.rdata[0] = wave_shadow[idx];
			end else if (r.lane[0].wstrb != 4'h0) begin
				priv_shadow[r.fw_core_select][idx] = merge_bytes(
					priv_shadow[r.fw_core_select][idx], r.lane[0].wdata, r.lane[0].wstrb);
			end else begin
				exp.rdata[r.fw_core_select] = priv_shadow[r.fw_core_select][idx];
			end
			return exp;
		end
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			a = r.lane[k].addr.raw;
			in_wave = r.lane[k].instr && a < `WM_INSTR_LIMIT;
			in_priv = a >= `WM_PRIV_BASE && a < `WM_PRIV_LIMIT;
			bad_mem = a < `WM_INSTR_LIMIT && (!r.lane[k].instr || r.lane[k].wstrb != 4'h0);
			if (r.lane[k].instr != r.lane[0].instr ||
					(r.lane[0].instr && a != r.lane[0].addr.raw)) begin
				exp.fault.lockstep = 1'b1;
			end
			if (bad_mem) begin
				exp.fault.mem = 1'b1;
			end
			if (!in_wave && !in_priv && !bad_mem) begin
				exp.fault.unmapped = 1'b1;
			end
		end
		if (exp.fault != 3'b000) begin
			return exp; // No memory touched
		end
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			idx = r.lane[k].addr.raw[11:2];
			if (r.lane[k].addr.raw < `WM_INSTR_LIMIT) begin
				exp.rdata[k] = wave_shadow[idx];
			end else if (r.lane[k].wstrb != 4'h0) begin
				priv_shadow[k][idx] = merge_bytes(priv_shadow[k][idx], r.lane[k].wdata,
					r.lane[k].wstrb);
			end else begin
				exp.rdata[k] = priv_shadow[k][idx];
			end
		end
		return exp;
	endfunction

	task automatic compare_rsp(input wave_mem_pkg::wave_rsp_t exp);
		checks++;
		if (exp.fault !== rsp.fault) begin
			errors++;
			$display("Fail %0s fault: expected %b, actual %b", test_name, exp.fault, rsp.fault);
		end
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			if (exp.rdata[k] !== rsp.rdata[k]) begin
				errors++;
				$display("Fail %0s lane %0d rdata: expected %h, actual %h", test_name, k,
					exp.rdata[k], rsp.rdata[k]);
			end
		end
	endtask

	// Handshakes sampled mid-cycle, where all inputs are settled
	always @(negedge clk) begin
		if (!nRST) begin
			checks = 0;
			errors = 0;
			expect_q.delete();
		end else begin
			if (req_valid && req_ready) begin
				expect_q.push_back(wave_ref(req));
			end
			if (rsp_valid && rsp_ready) begin
				if (expect_q.size() == 0) begin
					errors++;
					$display("A response arrived with no request outstanding");
				end else begin
					compare_rsp(expect_q.pop_front());
				end
			end
		end
		pending = expect_q.size();
	end

endmodule

// ==== tests/wave_mem_tb.sv ====
`timescale 1ns/1ps
`include "wave_mem_config.svh"

module wave_mem_tb;

	localparam int WAIT_LIMIT = 400; // Cycles per wait loop
	localparam logic [31:0] SEED = 32'd65;

	logic clk;
	logic nRST;
	logic req_valid;
	logic req_ready;
	wave_mem_pkg::wave_req_t req;
	logic rsp_valid;
	logic rsp_ready;
	wave_mem_pkg::wave_rsp_t rsp;

	logic [31:0] stim_state;
	logic [31:0] ready_state;
	logic bp_on; // Random rsp_ready when set
	logic timed_out;
	logic [8*12-1:0] test_name;
	int checks;
	int errors;
	int pending;
	int phase_checks0;
	int phase_errors0;

	wave_mem_top uut (
		.clk(clk),
		.nRST(nRST),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

	wave_mem_checker chk (
		.clk(clk),
		.nRST(nRST),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp),
		.test_name(test_name),
		.checks(checks),
		.errors(errors),
		.pending(pending)
	);

	bind wave_mem_top wave_mem_props props (
		.clk(clk),
		.nRST(nRST),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp(rsp)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function logic [31:0] draw_rand();
		stim_state = lcg_next(stim_state);
		return stim_state;
	endfunction

	// Picks one of the sixteen test words of a memory
	function logic [3:0] rand_idx();
		logic [31:0] r;
		r = draw_rand();
		return r[27:24];
	endfunction

	// Test word i sits at word index {i, 2'b00, i} so high and low index bits both toggle
	function automatic logic [31:0] word_addr(input logic [31:0] base, input logic [3:0] idx);
		return base + {20'h0, idx, 2'b00, idx, 2'b00};
	endfunction

	// Lanes 1 to 3 carry junk that the fabric ignores
	function automatic wave_mem_pkg::wave_req_t fw_req(input logic wave_sel,
			input logic [1:0] core, input logic [3:0] idx, input logic [3:0] wstrb,
			input logic [31:0] wdata);
		wave_mem_pkg::wave_req_t r;
		r = '0;
		for (int k = 1; k < `WM_CORE_COUNT; k++) begin
			r.lane[k].addr.raw = draw_rand();
			r.lane[k].wdata = draw_rand();
		end
		r.fw = 1'b1;
		r.fw_wave_select = wave_sel;
		r.fw_core_select = core;
		r.lane[0].addr.raw = word_addr(wave_sel ? 32'h0 : `WM_PRIV_BASE, idx);
		r.lane[0].wstrb = wstrb;
		r.lane[0].wdata = wdata;
		return r;
	endfunction

	function automatic wave_mem_pkg::wave_req_t fetch_req(input logic [3:0] idx);
		wave_mem_pkg::wave_req_t r;
		r = '0;
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			r.lane[k].instr = 1'b1;
			r.lane[k].addr.raw = word_addr(32'h0, idx);
			r.lane[k].wdata = draw_rand();
		end
		return r;
	endfunction

	function automatic wave_mem_pkg::wave_req_t data_req(input logic writes);
		wave_mem_pkg::wave_req_t r;
		logic [31:0] rnd;
		r = '0;
		for (int k = 0; k < `WM_CORE_COUNT; k++) begin
			rnd = draw_rand();
			r.lane[k].addr.raw = word_addr(`WM_PRIV_BASE, rnd[27:24]);
			r.lane[k].wstrb = writes ? rnd[23:20] : 4'h0;
			r.lane[k].wdata = draw_rand();
		end
		return r;
	endfunction

	// Kind 0 skews a fetch address and kind 1 mixes instr flags
	// Kind 2 is a data access below 0x1000 and higher kinds hit unmapped space
	function automatic wave_mem_pkg::wave_req_t fault_req(input logic [2:0] kind);
		wave_mem_pkg::wave_req_t r;
		logic [31:0] rnd;
		logic [1:0] l;
		r = data_req(1'b1); // Stray writes must not land
		rnd = draw_rand();
		l = (rnd[25:24] == 2'd0) ? 2'd1 : rnd[25:24];
		case (kind)
			3'd0: begin
				r = fetch_req(rand_idx());
				r.lane[l].addr.raw = r.lane[l].addr.raw + 32'd4;
			end
			3'd1: begin
				r.lane[0].instr = 1'b1;
				r.lane[0].addr.raw = word_addr(32'h0, rand_idx());
				r.lane[0].wstrb = 4'h0;
			end
			3'd2: r.lane[l].addr.raw = word_addr(32'h0, rand_idx());
			3'd3: r.lane[l].addr.raw = word_addr(32'h1000, rand_idx());
			default: r.lane[l].addr.raw = `WM_PRIV_LIMIT + (rnd & 32'h00ff_fffc);
		endcase
		return r;
	endfunction

	// Starts right after a rising edge and returns on the transfer edge
	task automatic send_req(input wave_mem_pkg::wave_req_t r);
		int waited;
		waited = 0;
		if (!timed_out) begin
			req <= r;
			req_valid <= 1'b1;
			@(negedge clk);
			while (!req_ready && waited < WAIT_LIMIT) begin
				waited++;
				@(negedge clk);
			end
			if (!req_ready) begin
				$display("Timeout: the DUT never accepted a request in %0s", test_name);
				timed_out = 1'b1;
			end
			@(posedge clk);
			req_valid <= 1'b0;
		end
	endtask

	// Firmware read of the sixteen test words in all five memories
	task automatic dump_all();
		for (int m = 0; m < 5; m++) begin
			for (int i = 0; i < 16; i++) begin
				send_req(fw_req(m == 4, 2'(m), 4'(i), 4'h0, draw_rand()));
			end
		end
	endtask

	task automatic start_phase(input logic [8*12-1:0] name);
		test_name = name;
		phase_checks0 = checks;
		phase_errors0 = errors;
	endtask

	task automatic finish_phase();
		int waited;
		waited = 0;
		while (pending != 0 && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge clk);
		end
		if (pending != 0 && !timed_out) begin
			$display("Timeout: %0d responses never arrived in %0s", pending, test_name);
			timed_out = 1'b1;
		end
		$display("%0s: %0d responses checked, %0d errors", test_name, checks - phase_checks0,
			errors - phase_errors0);
	endtask

	always @(posedge clk) begin
		ready_state <= lcg_next(ready_state);
		rsp_ready <= bp_on ? ready_state[28] : 1'b1;
	end

	initial begin
		logic [31:0] rnd;
		logic [3:0] strb;
		clk = 1'b0;
		nRST = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		bp_on = 1'b0;
		timed_out = 1'b0;
		stim_state = SEED;
		ready_state = SEED;
		test_name = "reset";
		repeat (3) @(posedge clk);
		nRST <= 1'b1;

		start_phase("fw_upload");
		for (int m = 0; m < 5; m++) begin
			for (int i = 0; i < 16; i++) begin
				send_req(fw_req(m == 4, 2'(m), 4'(i), 4'hf, draw_rand()));
			end
		end
		for (int j = 0; j < 25; j++) begin
			rnd = draw_rand();
			strb = (rnd[23:20] == 4'h0 || rnd[23:20] == 4'hf) ? 4'h5 :
				rnd[23:20]; // Partial writes only
			send_req(fw_req(j % 5 == 4, 2'(j % 5), rand_idx(), strb, draw_rand()));
		end
		dump_all();
		finish_phase();

		start_phase("fetch");
		for (int j = 0; j < 16; j++) begin
			send_req(fetch_req(rand_idx()));
		end
		finish_phase();

		start_phase("priv_data");
		for (int j = 0; j < 16; j++) begin
			send_req(data_req(1'b1));
		end
		for (int j = 0; j < 16; j++) begin
			send_req(data_req(1'b0));
		end
		dump_all();
		finish_phase();

		start_phase("faults");
		for (int j = 0; j < 10; j++) begin
			send_req(fault_req(3'(j % 5)));
		end
		dump_all();
		finish_phase();

		start_phase("backpressure");
		bp_on <= 1'b1;
		for (int j = 0; j < 80; j++) begin
			rnd = draw_rand();
			case (rnd[29:28])
				2'd0: send_req(fetch_req(rand_idx()));
				2'd1: send_req(data_req(rnd[20]));
				2'd2: send_req(fw_req(rnd[21], rnd[23:22], rand_idx(), rnd[27:24],
					draw_rand()));
				default: send_req(fault_req(rnd[26:24] % 3'd5));
			endcase
		end
		finish_phase();
		bp_on <= 1'b0;

		$display("Summary: %0d responses checked, %0d errors, %0s", checks, errors,
			timed_out ? "a wait timed out" : "no timeouts");
		if (timed_out || errors != 0) begin
			$display("TEST FAIL");
		end else begin
			$display("TEST PASS");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/wave_mem_pkg.sv
rtl/word_sram.sv
rtl/wave_req_decode.sv
rtl/wave_mem_access.sv
rtl/wave_mem_top.sv
tests/wave_mem_props.sv
tests/wave_mem_checker.sv
tests/wave_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the wave memory testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module wave_mem_tb -f files.f -o wave_mem_sim \
	> sim.log 2>&1 \
	&& ./obj_dir/wave_mem_sim >> sim.log 2>&1
cat sim.log
! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log || exit 1
